/* ucode_params.svh */
`ifndef UCODE_PARAMS_SVH
`define UCODE_PARAMS_SVH

// Opcode and flag byte as seen from the datapath
`define UCODE_OPCODE_W 8
`define UCODE_FLAGS_W 8

// One register or ALU field inside an opcode
`define UCODE_FIELD_W 3

// Stage counter, wide enough for the longest kept instruction
`define UCODE_STAGE_W 4

// Control word fields
`define UCODE_REG_SEL_W 5
`define UCODE_ALU_OP_W 5
`define UCODE_CTRL_W 33

// Stages 0 to 2 are the instruction fetch
`define UCODE_FETCH_STAGES 3

`endif

/* ucode_pkg.sv */
`include "ucode_params.svh"

package ucode_pkg;

	// Register file selectors with the top bit set for pairs
	typedef enum logic [`UCODE_REG_SEL_W-1:0] {
		SEL_B    = 5'd0,
		SEL_C    = 5'd1,
		SEL_D    = 5'd2,
		SEL_E    = 5'd3,
		SEL_H    = 5'd4,
		SEL_L    = 5'd5,
		SEL_W    = 5'd6,
		SEL_Z    = 5'd7,
		SEL_PC_P = 5'd8,
		SEL_PC_C = 5'd9,
		SEL_BC   = 5'd16,
		SEL_DE   = 5'd18,
		SEL_HL   = 5'd20,
		SEL_WZ   = 5'd22,
		SEL_PC   = 5'd24
	} reg_sel_e;

	// Pair increment on the selected write register
	typedef enum logic [1:0] {
		EXT_NONE = 2'd0,
		EXT_INC  = 2'd1,
		EXT_INC2 = 2'd3
	} reg_ext_e;

	typedef enum logic [`UCODE_ALU_OP_W-1:0] {
		ALU_ADD = 5'd0,
		ALU_ADC = 5'd1,
		ALU_SUB = 5'd2,
		ALU_SBB = 5'd3,
		ALU_ANA = 5'd4,
		ALU_XRA = 5'd5,
		ALU_ORA = 5'd6,
		ALU_CMP = 5'd7,
		ALU_RLC = 5'd8,
		ALU_RRC = 5'd9,
		ALU_RAL = 5'd10,
		ALU_RAR = 5'd11,
		ALU_DAA = 5'd12,
		ALU_CMA = 5'd13,
		ALU_STC = 5'd14,
		ALU_CMC = 5'd15,
		ALU_INC = 5'd16,
		ALU_DEC = 5'd17
	} alu_op_e;

	// MOV_RM loads a register from memory and MOV_MR stores one
	typedef enum logic [3:0] {
		GRP_NOP,
		GRP_HLT,
		GRP_MOV_RR,
		GRP_MOV_RM,
		GRP_MOV_MR,
		GRP_MVI_R,
		GRP_MVI_M,
		GRP_INR_R,
		GRP_INR_M,
		GRP_ALU_R,
		GRP_ALU_M,
		GRP_ALU_SET1,
		GRP_ALU_IMM,
		GRP_JMP,
		GRP_JCC,
		GRP_OUT
	} instr_group_e;

	// Bit 32 down to bit 0 of the datapath control word
	typedef struct packed {
		logic     display;
		logic     hlt;
		logic     alu_cs;
		logic     alu_flags_we;
		logic     alu_a_we;
		logic     alu_a_store;
		logic     alu_a_restore;
		logic     alu_tmp_we;
		alu_op_e  alu_op;
		logic     alu_oe;
		logic     alu_flags_oe;
		reg_sel_e reg_rd_sel;
		reg_sel_e reg_wr_sel;
		reg_ext_e reg_ext;
		logic     reg_oe;
		logic     reg_we;
		logic     mem_we;
		logic     mem_mar_we;
		logic     mem_oe;
		logic     ir_we;
	} ctrl_word_t;

endpackage

/* instr_if.sv */
`timescale 1ns/1ps
`include "ucode_params.svh"

interface instr_if;

	ucode_pkg::instr_group_e group;
	logic [`UCODE_FIELD_W-1:0] dst;
	logic [`UCODE_FIELD_W-1:0] src;
	ucode_pkg::alu_op_e alu_op;
	// Decrement select of INR/DCR
	logic dec;
	// Jump condition against the flag byte
	logic cond_met;

	modport producer (
		output group, dst, src, alu_op, dec, cond_met
	);

	modport consumer (
		input group, dst, src, alu_op, dec, cond_met
	);

endinterface

/* instr_decoder.sv */
`timescale 1ns/1ps
`include "ucode_params.svh"

module instr_decoder (
	input  logic [`UCODE_OPCODE_W-1:0] opcode,
	input  logic [`UCODE_FLAGS_W-1:0]  flags,
	instr_if.producer                  instr
);

	assign instr.dst = opcode[5:3];
	assign instr.src = opcode[2:0];
	assign instr.dec = opcode[0];

	// Flag chosen by bits 5:4 must match bit 3
	assign instr.cond_met = (flags[opcode[5:4]] == opcode[3]);

	// Earlier items win, so 0o166 is HLT and not MOV M,M
	always_comb begin
		instr.group = ucode_pkg::GRP_NOP;
		instr.alu_op = ucode_pkg::ALU_ADD;
		priority casez (opcode)
			8'o000: begin
				instr.group = ucode_pkg::GRP_NOP;
			end
			8'o166: begin
				instr.group = ucode_pkg::GRP_HLT;
			end
			8'o1?6: begin
				instr.group = ucode_pkg::GRP_MOV_RM;
			end
			8'o16?: begin
				instr.group = ucode_pkg::GRP_MOV_MR;
			end
			8'o1??: begin
				instr.group = ucode_pkg::GRP_MOV_RR;
			end
			8'o064, 8'o065: begin
				instr.group = ucode_pkg::GRP_INR_M;
				instr.alu_op = instr.dec ? ucode_pkg::ALU_DEC : ucode_pkg::ALU_INC;
			end
			8'o0?4, 8'o0?5: begin
				instr.group = ucode_pkg::GRP_INR_R;
				instr.alu_op = instr.dec ? ucode_pkg::ALU_DEC : ucode_pkg::ALU_INC;
			end
			8'o2?6: begin
				instr.group = ucode_pkg::GRP_ALU_M;
				instr.alu_op = ucode_pkg::alu_op_e'({2'b00, opcode[5:3]});
			end
			8'o2??: begin
				instr.group = ucode_pkg::GRP_ALU_R;
				instr.alu_op = ucode_pkg::alu_op_e'({2'b00, opcode[5:3]});
			end
			8'o0?7: begin
				instr.group = ucode_pkg::GRP_ALU_SET1;
				instr.alu_op = ucode_pkg::alu_op_e'({2'b01, opcode[5:3]});
			end
			8'o3?6: begin
				instr.group = ucode_pkg::GRP_ALU_IMM;
				instr.alu_op = ucode_pkg::alu_op_e'({2'b00, opcode[5:3]});
			end
			8'o066: begin
				instr.group = ucode_pkg::GRP_MVI_M;
			end
			8'o0?6: begin
				instr.group = ucode_pkg::GRP_MVI_R;
			end
			8'o303: begin
				instr.group = ucode_pkg::GRP_JMP;
			end
			8'o3?2: begin
				instr.group = ucode_pkg::GRP_JCC;
			end
			8'o323: begin
				instr.group = ucode_pkg::GRP_OUT;
			end
			// Everything else runs as NOP
			default: begin
				instr.group = ucode_pkg::GRP_NOP;
			end
		endcase
	end

endmodule

/* ucode_sequencer.sv */
`timescale 1ns/1ps
`include "ucode_params.svh"

module ucode_sequencer (
	input  logic                  clk,
	input  logic                  rst,
	instr_if.consumer             instr,
	output ucode_pkg::ctrl_word_t ctrl
);

	localparam logic [`UCODE_STAGE_W-1:0] FIRST_EXEC = `UCODE_STAGE_W'(`UCODE_FETCH_STAGES);
	localparam logic [`UCODE_FIELD_W-1:0] ACC = 3'd7;

	logic [`UCODE_STAGE_W-1:0] stage;
	logic stage_done;
	logic halted;

	// Selected pair onto the memory address latch
	function automatic ucode_pkg::ctrl_word_t addr_word(input ucode_pkg::reg_sel_e sel);
		ucode_pkg::ctrl_word_t w;
		w = '0;
		w.reg_rd_sel = sel;
		w.reg_oe = 1'b1;
		w.mem_mar_we = 1'b1;
		return w;
	endfunction

	function automatic ucode_pkg::ctrl_word_t pc_step(input ucode_pkg::reg_ext_e ext);
		ucode_pkg::ctrl_word_t w;
		w = '0;
		w.reg_wr_sel = ucode_pkg::SEL_PC;
		w.reg_ext = ext;
		return w;
	endfunction

	function automatic ucode_pkg::ctrl_word_t mem_to_reg(input ucode_pkg::reg_sel_e sel);
		ucode_pkg::ctrl_word_t w;
		w = '0;
		w.mem_oe = 1'b1;
		w.reg_wr_sel = sel;
		w.reg_we = 1'b1;
		return w;
	endfunction

	function automatic ucode_pkg::ctrl_word_t alu_word(input ucode_pkg::alu_op_e op);
		ucode_pkg::ctrl_word_t w;
		w = '0;
		w.alu_cs = 1'b1;
		w.alu_op = op;
		return w;
	endfunction

	// The accumulator sits in the ALU, not in the register file
	function automatic ucode_pkg::ctrl_word_t with_src(input ucode_pkg::ctrl_word_t w,
			input logic [`UCODE_FIELD_W-1:0] code);
		ucode_pkg::ctrl_word_t r;
		r = w;
		if (code == ACC) begin
			r.alu_oe = 1'b1;
		end else begin
			r.reg_rd_sel = ucode_pkg::reg_sel_e'({2'b00, code});
			r.reg_oe = 1'b1;
		end
		return r;
	endfunction

	function automatic ucode_pkg::ctrl_word_t with_dst(input ucode_pkg::ctrl_word_t w,
			input logic [`UCODE_FIELD_W-1:0] code);
		ucode_pkg::ctrl_word_t r;
		r = w;
		if (code == ACC) begin
			r.alu_a_we = 1'b1;
		end else begin
			r.reg_wr_sel = ucode_pkg::reg_sel_e'({2'b00, code});
			r.reg_we = 1'b1;
		end
		return r;
	endfunction

	assign halted = (instr.group == ucode_pkg::GRP_HLT) && (stage == FIRST_EXEC);

	always_ff @(posedge clk) begin
		if (rst) begin
			stage <= '0;
		end else if (stage_done) begin
			stage <= '0;
		end else if (!halted) begin
			stage <= stage + `UCODE_STAGE_W'(1);
		end
	end

	always_comb begin
		ctrl = '0;
		stage_done = 1'b0;
		if (stage < FIRST_EXEC) begin
			case (stage)
				4'd0: ctrl = addr_word(ucode_pkg::SEL_PC);
				4'd1: begin
					ctrl.mem_oe = 1'b1;
					ctrl.ir_we = 1'b1;
				end
				default: ctrl = pc_step(ucode_pkg::EXT_INC);
			endcase
		end else begin
			case (instr.group)
				ucode_pkg::GRP_HLT: begin
					ctrl.hlt = 1'b1;
				end
				ucode_pkg::GRP_MOV_RR: begin
					ctrl = with_dst(with_src(ctrl, instr.src), instr.dst);
					stage_done = 1'b1;
				end
				ucode_pkg::GRP_MOV_RM: begin
					if (stage == 4'd3) begin
						ctrl = addr_word(ucode_pkg::SEL_HL);
					end else begin
						ctrl = with_dst(ctrl, instr.dst);
						ctrl.mem_oe = 1'b1;
						stage_done = 1'b1;
					end
				end
				ucode_pkg::GRP_MOV_MR: begin
					if (stage == 4'd3) begin
						ctrl = addr_word(ucode_pkg::SEL_HL);
					end else begin
						ctrl = with_src(ctrl, instr.src);
						ctrl.mem_we = 1'b1;
						stage_done = 1'b1;
					end
				end
				ucode_pkg::GRP_MVI_R: begin
					case (stage)
						4'd3: ctrl = addr_word(ucode_pkg::SEL_PC);
						4'd4: begin
							ctrl = with_dst(ctrl, instr.dst);
							ctrl.mem_oe = 1'b1;
						end
						default: begin
							ctrl = pc_step(ucode_pkg::EXT_INC);
							stage_done = 1'b1;
						end
					endcase
				end
				// Immediate byte parks in W until HL is on the address latch
				ucode_pkg::GRP_MVI_M: begin
					case (stage)
						4'd3: ctrl = addr_word(ucode_pkg::SEL_PC);
						4'd4: ctrl = mem_to_reg(ucode_pkg::SEL_W);
						4'd5: ctrl = addr_word(ucode_pkg::SEL_HL);
						4'd6: begin
							ctrl.reg_rd_sel = ucode_pkg::SEL_W;
							ctrl.reg_oe = 1'b1;
							ctrl.mem_we = 1'b1;
						end
						default: begin
							ctrl = pc_step(ucode_pkg::EXT_INC);
							stage_done = 1'b1;
						end
					endcase
				end
				// Operand goes through A while the old A is stored aside
				ucode_pkg::GRP_INR_R: begin
					case (stage)
						4'd3: begin
							if (instr.dst == ACC) begin
								ctrl = alu_word(instr.alu_op);
								stage_done = 1'b1;
							end else begin
								ctrl = with_src(ctrl, instr.dst);
								ctrl.alu_a_store = 1'b1;
								ctrl.alu_a_we = 1'b1;
							end
						end
						4'd4: ctrl = alu_word(instr.alu_op);
						default: begin
							ctrl = with_dst(ctrl, instr.dst);
							ctrl.alu_oe = 1'b1;
							ctrl.alu_a_restore = 1'b1;
							stage_done = 1'b1;
						end
					endcase
				end
				ucode_pkg::GRP_INR_M: begin
					case (stage)
						4'd3: ctrl = addr_word(ucode_pkg::SEL_HL);
						4'd4: begin
							ctrl.mem_oe = 1'b1;
							ctrl.alu_a_store = 1'b1;
							ctrl.alu_a_we = 1'b1;
						end
						4'd5: ctrl = alu_word(instr.alu_op);
						default: begin
							ctrl.alu_oe = 1'b1;
							ctrl.alu_a_restore = 1'b1;
							ctrl.mem_we = 1'b1;
							stage_done = 1'b1;
						end
					endcase
				end
				ucode_pkg::GRP_ALU_R: begin
					if (stage == 4'd3 && instr.src != ACC) begin
						ctrl = with_src(ctrl, instr.src);
						ctrl.alu_tmp_we = 1'b1;
					end else begin
						ctrl = alu_word(instr.alu_op);
						ctrl.alu_tmp_we = (stage == 4'd3);
						stage_done = 1'b1;
					end
				end
				// Memory operand from HL, immediate operand from PC
				ucode_pkg::GRP_ALU_M, ucode_pkg::GRP_ALU_IMM: begin
					case (stage)
						4'd3: begin
							if (instr.group == ucode_pkg::GRP_ALU_M) begin
								ctrl = addr_word(ucode_pkg::SEL_HL);
							end else begin
								ctrl = addr_word(ucode_pkg::SEL_PC);
							end
						end
						4'd4: begin
							ctrl.mem_oe = 1'b1;
							ctrl.alu_tmp_we = 1'b1;
						end
						default: begin
							if (instr.group == ucode_pkg::GRP_ALU_IMM) begin
								ctrl = pc_step(ucode_pkg::EXT_INC);
							end
							ctrl.alu_cs = 1'b1;
							ctrl.alu_op = instr.alu_op;
							stage_done = 1'b1;
						end
					endcase
				end
				ucode_pkg::GRP_ALU_SET1: begin
					ctrl = alu_word(instr.alu_op);
					stage_done = 1'b1;
				end
				// Target is assembled low byte first in WZ
				ucode_pkg::GRP_JMP, ucode_pkg::GRP_JCC: begin
					case (stage)
						4'd3: begin
							if (instr.group == ucode_pkg::GRP_JCC && !instr.cond_met) begin
								// Skip both address bytes
								ctrl = pc_step(ucode_pkg::EXT_INC2);
								stage_done = 1'b1;
							end else begin
								ctrl = addr_word(ucode_pkg::SEL_PC);
							end
						end
						4'd4: ctrl = mem_to_reg(ucode_pkg::SEL_Z);
						4'd5: ctrl = pc_step(ucode_pkg::EXT_INC);
						4'd6: ctrl = addr_word(ucode_pkg::SEL_PC);
						4'd7: ctrl = mem_to_reg(ucode_pkg::SEL_W);
						default: begin
							ctrl.reg_rd_sel = ucode_pkg::SEL_WZ;
							ctrl.reg_oe = 1'b1;
							ctrl.reg_wr_sel = ucode_pkg::SEL_PC;
							ctrl.reg_we = 1'b1;
							stage_done = 1'b1;
						end
					endcase
				end
				ucode_pkg::GRP_OUT: begin
					ctrl = pc_step(ucode_pkg::EXT_INC);
					ctrl.display = 1'b1;
					stage_done = 1'b1;
				end
				// NOP and every unclassified opcode
				default: begin
					stage_done = 1'b1;
				end
			endcase
		end
	end

endmodule

/* ucode_controller.sv */
`timescale 1ns/1ps
`include "ucode_params.svh"

module ucode_controller (
	input  logic                       clk,
	input  logic                       rst,
	input  logic [`UCODE_OPCODE_W-1:0] opcode,
	input  logic [`UCODE_FLAGS_W-1:0]  flags,
	output logic [`UCODE_CTRL_W-1:0]   ctrl_out
);

	ucode_pkg::ctrl_word_t ctrl;

	instr_if instr ();

	instr_decoder u_decoder (
		.opcode (opcode),
		.flags  (flags),
		.instr  (instr)
	);

	ucode_sequencer u_sequencer (
		.clk   (clk),
		.rst   (rst),
		.instr (instr),
		.ctrl  (ctrl)
	);

	// Struct fields already sit in datapath bit order
	assign ctrl_out = ctrl;

endmodule

/* tb_ucode_checks.svh */
`ifndef TB_UCODE_CHECKS_SVH
`define TB_UCODE_CHECKS_SVH

int word_errors = 0;
int length_errors = 0;
int other_errors = 0;

logic [31:0] lcg_state = 32'h7fec;

function automatic logic [31:0] lcg_next();
	lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
	return lcg_state;
endfunction

// Middle bits of the LCG vary the most
function automatic logic [7:0] random_flags();
	logic [31:0] r;
	r = lcg_next();
	return r[23:16];
endfunction

function automatic ucode_pkg::ctrl_word_t fetch_word(input int stage);
	ucode_pkg::ctrl_word_t w;
	w = '0;
	if (stage == 0) begin
		w.reg_rd_sel = ucode_pkg::SEL_PC;
		w.reg_oe = 1'b1;
		w.mem_mar_we = 1'b1;
	end else if (stage == 1) begin
		w.mem_oe = 1'b1;
		w.ir_we = 1'b1;
	end else begin
		w.reg_wr_sel = ucode_pkg::SEL_PC;
		w.reg_ext = ucode_pkg::EXT_INC;
	end
	return w;
endfunction

// HL onto the memory address latch
function automatic ucode_pkg::ctrl_word_t hl_address();
	ucode_pkg::ctrl_word_t w;
	w = '0;
	w.reg_rd_sel = ucode_pkg::SEL_HL;
	w.reg_oe = 1'b1;
	w.mem_mar_we = 1'b1;
	return w;
endfunction

// Code 7 is the accumulator, driven by the ALU
function automatic ucode_pkg::ctrl_word_t read_reg(input ucode_pkg::ctrl_word_t base,
		input logic [2:0] code);
	ucode_pkg::ctrl_word_t w;
	w = base;
	if (code == 3'd7) begin
		w.alu_oe = 1'b1;
	end else begin
		w.reg_rd_sel = ucode_pkg::reg_sel_e'({2'b00, code});
		w.reg_oe = 1'b1;
	end
	return w;
endfunction

function automatic ucode_pkg::ctrl_word_t write_reg(input ucode_pkg::ctrl_word_t base,
		input logic [2:0] code);
	ucode_pkg::ctrl_word_t w;
	w = base;
	if (code == 3'd7) begin
		w.alu_a_we = 1'b1;
	end else begin
		w.reg_wr_sel = ucode_pkg::reg_sel_e'({2'b00, code});
		w.reg_we = 1'b1;
	end
	return w;
endfunction

function automatic ucode_pkg::ctrl_word_t pc_word(input ucode_pkg::reg_ext_e ext);
	ucode_pkg::ctrl_word_t w;
	w = '0;
	w.reg_wr_sel = ucode_pkg::SEL_PC;
	w.reg_ext = ext;
	return w;
endfunction

function automatic ucode_pkg::ctrl_word_t alu_result(input ucode_pkg::alu_op_e op);
	ucode_pkg::ctrl_word_t w;
	w = '0;
	w.alu_cs = 1'b1;
	w.alu_op = op;
	return w;
endfunction

// WZ copied into PC
function automatic ucode_pkg::ctrl_word_t jump_word();
	ucode_pkg::ctrl_word_t w;
	w = '0;
	w.reg_rd_sel = ucode_pkg::SEL_WZ;
	w.reg_oe = 1'b1;
	w.reg_wr_sel = ucode_pkg::SEL_PC;
	w.reg_we = 1'b1;
	return w;
endfunction

function automatic ucode_pkg::ctrl_word_t halt_word();
	ucode_pkg::ctrl_word_t w;
	w = '0;
	w.hlt = 1'b1;
	return w;
endfunction

task automatic check_word(input ucode_pkg::ctrl_word_t got, input ucode_pkg::ctrl_word_t exp,
		input string what);
	if (got !== exp) begin
		word_errors++;
		$display("** Error at %0d ns: %s, word %h, expected %h", $time, what, got, exp);
	end
endtask

task automatic check_length(input int got, input int exp, input string what);
	if (got != exp) begin
		length_errors++;
		$display("** Error at %0d ns: %s, length %0d cycles, expected %0d", $time, what, got,
			exp);
	end
endtask

`endif

/* tb_ucode_controller.sv */
`timescale 1ns/1ps
`include "ucode_params.svh"

module tb_ucode_controller;

	localparam int CLK_HALF = 5;
	localparam int MAX_CYCLES = 16;
	localparam int HALT_CYCLES = 20;

	// A length of 0 marks HLT, which never ends
	// A mid_stage of 0 means no inner word is checked
	typedef struct {
		logic [7:0]            opcode;
		logic [7:0]            flags;
		int                    len;
		ucode_pkg::ctrl_word_t final_word;
		int                    mid_stage;
		ucode_pkg::ctrl_word_t mid_word;
	} row_t;

	logic clk;
	logic rst;
	logic [`UCODE_OPCODE_W-1:0] opcode;
	logic [`UCODE_FLAGS_W-1:0] flags;
	logic [`UCODE_CTRL_W-1:0] ctrl_out;
	ucode_pkg::ctrl_word_t word_now;
	row_t rows[$];
	bit table_ready = 1'b0;

	`include "tb_ucode_checks.svh"

	assign word_now = ctrl_out;

	ucode_controller dut0 (
		.clk      (clk),
		.rst      (rst),
		.opcode   (opcode),
		.flags    (flags),
		.ctrl_out (ctrl_out)
	);

	initial begin
		clk = 1'b0;
		forever #CLK_HALF clk = ~clk;
	end

	task automatic add_row(input logic [7:0] op, input logic [7:0] fl, input int len,
			input ucode_pkg::ctrl_word_t fw);
		row_t r;
		r.opcode = op;
		r.flags = fl;
		r.len = len;
		r.final_word = fw;
		r.mid_stage = 0;
		r.mid_word = '0;
		rows.push_back(r);
	endtask

	// Inner word for the row added last
	task automatic expect_mid(input int stage, input ucode_pkg::ctrl_word_t mw);
		row_t r;
		r = rows.pop_back();
		r.mid_stage = stage;
		r.mid_word = mw;
		rows.push_back(r);
	endtask

	// Flag bit picked by opcode bits 5:4 must equal bit 3
	function automatic bit jump_taken(input logic [7:0] op, input logic [7:0] fl);
		logic f;
		case (op[5:4])
			2'd0: f = fl[0];
			2'd1: f = fl[1];
			2'd2: f = fl[2];
			default: f = fl[3];
		endcase
		return f == op[3];
	endfunction

	task automatic add_jump_row(input logic [7:0] op, input logic [7:0] fl);
		if (jump_taken(op, fl)) begin
			add_row(op, fl, 9, jump_word());
		end else begin
			add_row(op, fl, 4, pc_word(ucode_pkg::EXT_INC2));
		end
	endtask

	task automatic build_table();
		ucode_pkg::ctrl_word_t zero;
		ucode_pkg::ctrl_word_t w;
		zero = '0;
		add_row(8'o000, random_flags(), 4, zero);
		add_row(8'o101, random_flags(), 4, write_reg(read_reg(zero, 3'd1), 3'd0));
		add_row(8'o173, random_flags(), 4, write_reg(read_reg(zero, 3'd3), 3'd7));
		add_row(8'o157, random_flags(), 4, write_reg(read_reg(zero, 3'd7), 3'd5));
		w = write_reg(zero, 3'd2);
		w.mem_oe = 1'b1;
		add_row(8'o126, random_flags(), 5, w);
		expect_mid(3, hl_address());
		w = write_reg(zero, 3'd7);
		w.mem_oe = 1'b1;
		add_row(8'o176, random_flags(), 5, w);
		w = read_reg(zero, 3'd4);
		w.mem_we = 1'b1;
		add_row(8'o164, random_flags(), 5, w);
		expect_mid(3, hl_address());
		w = read_reg(zero, 3'd7);
		w.mem_we = 1'b1;
		add_row(8'o167, random_flags(), 5, w);
		// Immediate byte lands in the destination one word after its address
		w = write_reg(zero, 3'd1);
		w.mem_oe = 1'b1;
		add_row(8'o016, random_flags(), 6, pc_word(ucode_pkg::EXT_INC));
		expect_mid(4, w);
		w = write_reg(zero, 3'd7);
		w.mem_oe = 1'b1;
		add_row(8'o076, random_flags(), 6, pc_word(ucode_pkg::EXT_INC));
		expect_mid(4, w);
		add_row(8'o066, random_flags(), 8, pc_word(ucode_pkg::EXT_INC));
		expect_mid(5, hl_address());
		// INR/DCR on a register restores A in the last word
		w = write_reg(zero, 3'd3);
		w.alu_oe = 1'b1;
		w.alu_a_restore = 1'b1;
		add_row(8'o034, random_flags(), 6, w);
		w = write_reg(zero, 3'd4);
		w.alu_oe = 1'b1;
		w.alu_a_restore = 1'b1;
		add_row(8'o045, random_flags(), 6, w);
		add_row(8'o074, random_flags(), 4, alu_result(ucode_pkg::ALU_INC));
		add_row(8'o075, random_flags(), 4, alu_result(ucode_pkg::ALU_DEC));
		w = zero;
		w.alu_oe = 1'b1;
		w.alu_a_restore = 1'b1;
		w.mem_we = 1'b1;
		add_row(8'o064, random_flags(), 7, w);
		expect_mid(3, hl_address());
		add_row(8'o065, random_flags(), 7, w);
		add_row(8'o200, random_flags(), 5, alu_result(ucode_pkg::ALU_ADD));
		add_row(8'o225, random_flags(), 5, alu_result(ucode_pkg::ALU_SUB));
		w = alu_result(ucode_pkg::ALU_CMP);
		w.alu_tmp_we = 1'b1;
		add_row(8'o277, random_flags(), 4, w);
		add_row(8'o256, random_flags(), 6, alu_result(ucode_pkg::ALU_XRA));
		w = alu_result(ucode_pkg::ALU_ORA);
		w.reg_wr_sel = ucode_pkg::SEL_PC;
		w.reg_ext = ucode_pkg::EXT_INC;
		add_row(8'o366, random_flags(), 6, w);
		w.alu_op = ucode_pkg::ALU_ADD;
		add_row(8'o306, random_flags(), 6, w);
		add_row(8'o007, random_flags(), 4, alu_result(ucode_pkg::ALU_RLC));
		add_row(8'o077, random_flags(), 4, alu_result(ucode_pkg::ALU_CMC));
		add_row(8'o047, random_flags(), 4, alu_result(ucode_pkg::ALU_DAA));
		add_row(8'o303, random_flags(), 9, jump_word());
		add_jump_row(8'o302, 8'h00);
		add_jump_row(8'o302, 8'h01);
		add_jump_row(8'o332, 8'h02);
		add_jump_row(8'o352, 8'h00);
		add_jump_row(8'o372, 8'h08);
		add_jump_row(8'o362, 8'hff);
		w = pc_word(ucode_pkg::EXT_INC);
		w.display = 1'b1;
		add_row(8'o323, random_flags(), 4, w);
		// Dropped opcodes run as NOP
		add_row(8'o311, random_flags(), 4, zero);
		add_row(8'o041, random_flags(), 4, zero);
		add_row(8'o305, random_flags(), 4, zero);
		add_row(8'o043, random_flags(), 4, zero);
		add_row(8'o166, random_flags(), 0, halt_word());
	endtask

	task automatic watch_halt(input ucode_pkg::ctrl_word_t exp, input string tag);
		for (int k = 0; k < HALT_CYCLES; k++) begin
			@(negedge clk);
			check_word(word_now, exp, $sformatf("%s, halt cycle %0d", tag, k));
		end
	endtask

	initial begin
		int limit_ns;
		wait (table_ready);
		limit_ns = (rows.size() * 16 + 32) * 10;
		#(limit_ns);
		$display("Watchdog timeout, the test did not finish within %0d ns", limit_ns);
		$display("SIMULATION FAILED");
		$finish;
	end

	initial begin
		ucode_pkg::ctrl_word_t words[$];
		ucode_pkg::ctrl_word_t zero_word;
		row_t r;
		string tag;
		int measured;
		zero_word = '0;
		rst = 1'b1;
		opcode = '0;
		flags = '0;
		build_table();
		table_ready = 1'b1;
		repeat (16) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		check_word(word_now, fetch_word(0), "stage 0 after reset");
		@(negedge clk);
		check_word(word_now, fetch_word(1), "stage 1 after reset");

		// Each row starts at stage 2; the stages before it belong to the previous row
		foreach (rows[i]) begin
			r = rows[i];
			tag = $sformatf("row %0d opcode %o", i, r.opcode);
			@(posedge clk);
			opcode <= r.opcode;
			flags <= r.flags;
			@(negedge clk);
			check_word(word_now, fetch_word(2), {tag, ", stage 2"});
			if (r.len == 0) begin
				watch_halt(r.final_word, tag);
			end else begin
				words.delete();
				words.push_back(zero_word);
				words.push_back(zero_word);
				words.push_back(word_now);
				measured = 0;
				// ir_we marks stage 1 of the next instruction
				while (measured == 0 && words.size() <= MAX_CYCLES) begin
					@(negedge clk);
					words.push_back(word_now);
					if (word_now.ir_we) begin
						measured = words.size() - 2;
					end
				end
				if (measured == 0) begin
					other_errors++;
					$display("%s did not return to the fetch within %0d cycles", tag,
						MAX_CYCLES);
				end else begin
					check_length(measured, r.len, tag);
					if (r.len <= measured) begin
						check_word(words[r.len - 1], r.final_word, {tag, ", final word"});
					end
					if (r.mid_stage != 0 && r.mid_stage < measured) begin
						check_word(words[r.mid_stage], r.mid_word, {tag, ", inner word"});
					end
					check_word(words[measured], fetch_word(0), {tag, ", next stage 0"});
					check_word(words[measured + 1], fetch_word(1), {tag, ", next stage 1"});
				end
			end
		end

		$display("Errors: word %0d, length %0d, other %0d", word_errors, length_errors,
			other_errors);
		if (word_errors + length_errors + other_errors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

/* ucode_controller.f */
+incdir+.
ucode_pkg.sv
instr_if.sv
instr_decoder.sv
ucode_sequencer.sv
ucode_controller.sv
tb_ucode_controller.sv

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=tb_ucode_controller

verilator --binary --timing -f ucode_controller.f --top-module tb_ucode_controller \
	--Mdir obj_dir -o "$BIN"
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "SIMULATION FAILED" "$LOG"; then
	exit 1
fi

exit 0
